// File: wdata_pkg.sv
// shared types for the write data generator; size codes 0 and 1 are treated as a full bus.
`default_nettype none

package wdata_pkg;

    // --------------------------------------------------
    // widths with a meaning.
    // --------------------------------------------------
    localparam int word_w        = 32;
    localparam int wrap_min_bits = 10;

    typedef logic [word_w-1:0] word_t;
    typedef logic [2:0]        size_t;
    typedef logic [7:0]        len_t;
    typedef logic [3:0]        wrap_len_t;

    typedef enum logic [1:0] {
        idle,
        bias,
        run,
        done
    } gen_state_t;

    // --------------------------------------------------
    // words moved per beat for an axi size code.
    // --------------------------------------------------
    function automatic int unsigned words_per_beat(size_t size, int unsigned bus_words);
        int unsigned k;
        if (size < 3'd2)
            k = bus_words;
        else
            k = 32'd1 << (size - 3'd2);
        // sizes wider than the bus send a full bus.
        if (k > bus_words)
            k = bus_words;
        return k;
    endfunction

endpackage

`default_nettype wire

// File: wdata_ctrl.sv
// run control for the generator; config must hold from start until the final beat is accepted.
`timescale 1ns/1ps
`default_nettype none

module wdata_ctrl
    import wdata_pkg::*;
#(
    parameter int count_w = 16
)
(
    input  wire                clk,
    input  wire                rst_n,
    input  wire                start,
    input  wire  [count_w-1:0] total_beats,
    input  wire  len_t         burst_len,
    input  wire                slot_free,
    output logic               load,
    output logic               beat_fire,
    output logic               advance,
    output logic               beat_last,
    output logic [4:0]         lane_idx
);

    gen_state_t         state;
    gen_state_t         state_nxt;
    logic [count_w-1:0] beat_cnt;
    len_t               burst_cnt;

    // --------------------------------------------------
    // state machine.
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= idle;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            idle:
                if (start)
                    state_nxt = bias;
            bias:
                state_nxt = run;
            run:
                if (beat_cnt == '0)
                    state_nxt = done;
            done:
                state_nxt = idle;
            default:
                state_nxt = idle;
        endcase
    end

    assign load      = (state == bias);
    assign advance   = (state == run) && slot_free;
    assign beat_fire = advance && (beat_cnt != '0);
    assign beat_last = beat_fire && (burst_cnt == '0);

    // --------------------------------------------------
    // counters.
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            beat_cnt <= '0;
        else if (load)
            beat_cnt <= total_beats;
        else if (beat_fire)
            beat_cnt <= beat_cnt - 1'b1;
    end

    // burst counter reloads once the last beat of a burst leaves.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            burst_cnt <= '0;
        else if (load || beat_last)
            burst_cnt <= burst_len;
        else if (beat_fire)
            burst_cnt <= burst_cnt - 1'b1;
    end

    // lane walk restarts on every burst.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            lane_idx <= '0;
        else if (load || beat_last)
            lane_idx <= '0;
        else if (beat_fire)
            lane_idx <= lane_idx + 1'b1;
    end

endmodule

`default_nettype wire

// File: wdata_pattern.sv
// incrementing 32-bit pattern; in wrap mode only the low 10+wrap_len bits count.
`timescale 1ns/1ps
`default_nettype none

module wdata_pattern
    import wdata_pkg::*;
#(
    parameter int data_w = 256
)
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire            load,
    input  wire            advance,
    input  wire word_t     init_data,
    input  wire size_t     size,
    input  wire            wrap_mode,
    input  wire wrap_len_t wrap_len,
    output word_t          base
);

    localparam int unsigned bus_words = data_w / word_w;

    word_t step;
    word_t base_incr;
    word_t wrap_mask;
    word_t base_nxt;

    // --------------------------------------------------
    // next pattern value.
    // --------------------------------------------------
    always_comb
    begin
        step      = word_t'(words_per_beat(size, bus_words));
        base_incr = base + step;
        wrap_mask = (word_t'(1) << (wrap_min_bits + int'(wrap_len))) - word_t'(1);
        // upper bits stay those of the old base.
        if (wrap_mode)
            base_nxt = (base & ~wrap_mask) | (base_incr & wrap_mask);
        else
            base_nxt = base_incr;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            base <= '0;
        else if (load)
            base <= init_data;
        else if (advance)
            base <= base_nxt;
    end

endmodule

`default_nettype wire

// File: wdata_lane_mux.sv
// places the word group on its lanes; data_w must be a power of two of at least 64.
`timescale 1ns/1ps
`default_nettype none

module wdata_lane_mux
    import wdata_pkg::*;
#(
    parameter int data_w = 256
)
(
    input  wire word_t          base,
    input  wire size_t          size,
    input  wire  [4:0]          lane_idx,
    output logic [data_w-1:0]   lane_data,
    output logic [data_w/8-1:0] lane_strb
);

    localparam int unsigned bus_words  = data_w / word_w;
    localparam int unsigned word_bytes = word_w / 8;

    // --------------------------------------------------
    // group select and fill.
    // --------------------------------------------------
    always_comb
    begin : lane_fill
        int unsigned k;
        int unsigned first;
        lane_data = '0;
        lane_strb = '0;
        k         = words_per_beat(size, bus_words);
        // group start, in words.
        first     = (int'(lane_idx) * k) % bus_words;
        for (int unsigned w = 0; w < bus_words; w++)
        begin
            if ((w >= first) && (w < first + k))
            begin
                lane_data[w*word_w +: word_w]         = base + word_t'(w - first);
                lane_strb[w*word_bytes +: word_bytes] = '1;
            end
        end
    end

endmodule

`default_nettype wire

// File: wdata_out_stage.sv
// one-beat output register; data, strobe and last hold while wvalid waits for wready.
`timescale 1ns/1ps
`default_nettype none

module wdata_out_stage #(
    parameter int data_w = 256
)
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 beat_fire,
    input  wire  [data_w-1:0]   lane_data,
    input  wire  [data_w/8-1:0] lane_strb,
    input  wire                 beat_last,
    input  wire                 wready,
    output logic [data_w-1:0]   wdata,
    output logic [data_w/8-1:0] wstrb,
    output logic                wvalid,
    output logic                wlast,
    output logic                slot_free
);

    // slot frees as the held beat is taken.
    assign slot_free = !wvalid || wready;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            wvalid <= 1'b0;
        else if (beat_fire)
            wvalid <= 1'b1;
        else if (wready)
            wvalid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wdata <= '0;
            wstrb <= '0;
            wlast <= 1'b0;
        end
        else if (beat_fire)
        begin
            wdata <= lane_data;
            wstrb <= lane_strb;
            wlast <= beat_last;
        end
        // last drops with the beat it marked.
        else if (wready)
            wlast <= 1'b0;
    end

endmodule

`default_nettype wire

// File: wdata_gen.sv
// axi write data generator; config inputs stable from start to last accepted beat, start taken in idle.
`timescale 1ns/1ps
`default_nettype none

module wdata_gen
    import wdata_pkg::*;
#(
    parameter int data_w  = 256,
    parameter int count_w = 16
)
(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 start,
    input  wire  [count_w-1:0]  total_beats,
    input  wire size_t          size,
    input  wire len_t           burst_len,
    input  wire                 wrap_mode,
    input  wire wrap_len_t      wrap_len,
    input  wire word_t          init_data,
    input  wire                 wready,
    output logic [data_w-1:0]   wdata,
    output logic [data_w/8-1:0] wstrb,
    output logic                wvalid,
    output logic                wlast
);

    logic                load;
    logic                beat_fire;
    logic                advance;
    logic                beat_last;
    logic [4:0]          lane_idx;
    logic                slot_free;
    word_t               base;
    logic [data_w-1:0]   lane_data;
    logic [data_w/8-1:0] lane_strb;

    // --------------------------------------------------
    // control.
    // --------------------------------------------------
    wdata_ctrl #(
        .count_w     (count_w)
    ) wdata_ctrl_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .total_beats (total_beats),
        .burst_len   (burst_len),
        .slot_free   (slot_free),
        .load        (load),
        .beat_fire   (beat_fire),
        .advance     (advance),
        .beat_last   (beat_last),
        .lane_idx    (lane_idx)
    );

    // --------------------------------------------------
    // data path.
    // --------------------------------------------------
    wdata_pattern #(
        .data_w    (data_w)
    ) wdata_pattern_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .advance   (advance),
        .init_data (init_data),
        .size      (size),
        .wrap_mode (wrap_mode),
        .wrap_len  (wrap_len),
        .base      (base)
    );

    wdata_lane_mux #(
        .data_w    (data_w)
    ) wdata_lane_mux_inst (
        .base      (base),
        .size      (size),
        .lane_idx  (lane_idx),
        .lane_data (lane_data),
        .lane_strb (lane_strb)
    );

    wdata_out_stage #(
        .data_w    (data_w)
    ) wdata_out_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .beat_fire (beat_fire),
        .lane_data (lane_data),
        .lane_strb (lane_strb),
        .beat_last (beat_last),
        .wready    (wready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wlast     (wlast),
        .slot_free (slot_free)
    );

endmodule

`default_nettype wire

// File: wdata_props.sv
// channel rule checks bound into wdata_gen; hold and last rules are off while rst_n is low.
`timescale 1ns/1ps
`default_nettype none

module wdata_props #(
    parameter int data_w = 256
)
(
    input wire                clk,
    input wire                rst_n,
    input wire [data_w-1:0]   wdata,
    input wire [data_w/8-1:0] wstrb,
    input wire                wvalid,
    input wire                wready,
    input wire                wlast
);

    // no valid beat out of a reset cycle.
    reset_quiet: assert property (@(posedge clk) !rst_n |=> !wvalid)
        else $error("wvalid high after a reset cycle");

    // a beat that is not taken stays put.
    beat_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (wvalid && !wready) |=>
            (wvalid && $stable(wdata) && $stable(wstrb) && $stable(wlast)))
        else $error("write data channel changed while stalled");

    // wlast only with a valid beat.
    last_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
        wlast |-> wvalid)
        else $error("wlast high without wvalid");

endmodule

bind wdata_gen wdata_props #(
    .data_w (data_w)
) wdata_props_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .wvalid (wvalid),
    .wready (wready),
    .wlast  (wlast)
);

`default_nettype wire

// File: tb_wdata_gen.sv
// directed testbench for wdata_gen at data_w 256; outputs are sampled on the falling clock edge.
`timescale 1ns/1ps
`default_nettype none

module tb_wdata_gen;

    localparam int data_w    = 256;
    localparam int count_w   = 16;
    localparam int bus_words = data_w / 32;
    localparam int strb_w    = data_w / 8;
    localparam int timeout   = 2000;

    logic               clk;
    logic               rst_n;
    logic               start;
    logic [count_w-1:0] total_beats;
    logic [2:0]         size;
    logic [7:0]         burst_len;
    logic               wrap_mode;
    logic [3:0]         wrap_len;
    logic [31:0]        init_data;
    logic               wready;
    logic [data_w-1:0]  wdata;
    logic [strb_w-1:0]  wstrb;
    logic               wvalid;
    logic               wlast;

    logic [data_w-1:0]  exp_data[$];
    logic [strb_w-1:0]  exp_strb[$];
    logic               exp_last[$];
    logic [data_w-1:0]  last_seen_data;
    int                 err_cnt;
    int                 test_cnt;

    wdata_gen #(
        .data_w      (data_w),
        .count_w     (count_w)
    ) wdata_gen_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .total_beats (total_beats),
        .size        (size),
        .burst_len   (burst_len),
        .wrap_mode   (wrap_mode),
        .wrap_len    (wrap_len),
        .init_data   (init_data),
        .wready      (wready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wlast       (wlast)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------
    // reference model.
    // --------------------------------------------------
    function automatic int group_words(input logic [2:0] sz);
        int k;
        k = (1 << sz) / 4;
        if (sz < 3'd2 || k > bus_words)
            k = bus_words;
        return k;
    endfunction

    function automatic logic [31:0] next_base(input logic [31:0] base, input int k,
                                              input logic wm, input logic [3:0] wl);
        logic [31:0] sum;
        logic [31:0] mask;
        sum  = base + 32'(k);
        mask = (32'd1 << (10 + wl)) - 32'd1;
        if (wm)
            return (base & ~mask) | (sum & mask);
        return sum;
    endfunction

    task automatic build_expected(input int total, input logic [2:0] sz, input logic [7:0] bl,
                                  input logic wm, input logic [3:0] wl, input logic [31:0] init);
        int                k;
        int                first;
        int                in_burst;
        logic [31:0]       base;
        logic [data_w-1:0] d;
        logic [strb_w-1:0] s;
        k        = group_words(sz);
        base     = init;
        in_burst = 0;
        exp_data.delete();
        exp_strb.delete();
        exp_last.delete();
        for (int n = 0; n < total; n++)
        begin
            d     = '0;
            s     = '0;
            first = (in_burst * k) % bus_words;
            for (int j = 0; j < k; j++)
            begin
                d[(first + j)*32 +: 32] = base + 32'(j);
                s[(first + j)*4 +: 4]   = 4'hf;
            end
            exp_data.push_back(d);
            exp_strb.push_back(s);
            exp_last.push_back(in_burst == int'(bl));
            in_burst = (in_burst == int'(bl)) ? 0 : in_burst + 1;
            base     = next_base(base, k, wm, wl);
        end
    endtask

    // --------------------------------------------------
    // drive and collect.
    // --------------------------------------------------
    task automatic start_run(input int total, input logic [2:0] sz, input logic [7:0] bl,
                             input logic wm, input logic [3:0] wl, input logic [31:0] init);
        @(posedge clk);
        #1;
        total_beats = count_w'(total);
        size        = sz;
        burst_len   = bl;
        wrap_mode   = wm;
        wrap_len    = wl;
        init_data   = init;
        start       = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic collect_beats(input bit random_ready, output int first_valid);
        int                cycles;
        logic              held;
        logic [data_w-1:0] held_data;
        logic [strb_w-1:0] held_strb;
        logic              held_last;
        cycles      = 0;
        first_valid = -1;
        held        = 1'b0;
        while (exp_data.size() > 0 && cycles < timeout)
        begin
            @(negedge clk);
            cycles++;
            if (wvalid && first_valid < 0)
                first_valid = cycles;
            if (held)
            begin
                assert (wvalid) else begin
                    $display("held beat dropped before wready");
                    err_cnt++;
                end
                assert (wdata === held_data) else begin
                    $display("CHECK FAILED wdata: got %h expected %h while stalled",
                             wdata, held_data);
                    err_cnt++;
                end
                assert (wstrb === held_strb) else begin
                    $display("CHECK FAILED wstrb: got %h expected %h while stalled",
                             wstrb, held_strb);
                    err_cnt++;
                end
                assert (wlast === held_last) else begin
                    $display("CHECK FAILED wlast: got %h expected %h while stalled",
                             wlast, held_last);
                    err_cnt++;
                end
            end
            held = wvalid && !wready;
            held_data = wdata;
            held_strb = wstrb;
            held_last = wlast;
            if (wvalid && wready)
            begin
                assert (wdata === exp_data[0]) else begin
                    $display("CHECK FAILED wdata: got %h expected %h", wdata, exp_data[0]);
                    err_cnt++;
                end
                assert (wstrb === exp_strb[0]) else begin
                    $display("CHECK FAILED wstrb: got %h expected %h", wstrb, exp_strb[0]);
                    err_cnt++;
                end
                assert (wlast === exp_last[0]) else begin
                    $display("CHECK FAILED wlast: got %h expected %h", wlast, exp_last[0]);
                    err_cnt++;
                end
                last_seen_data = wdata;
                void'(exp_data.pop_front());
                void'(exp_strb.pop_front());
                void'(exp_last.pop_front());
            end
            @(posedge clk);
            #1;
            if (random_ready)
                wready = ($urandom % 3) != 0;
        end
        wready = 1'b1;
        if (exp_data.size() > 0)
        begin
            $display("timeout with %0d beats still missing", exp_data.size());
            err_cnt++;
        end
    endtask

    task automatic run_checked(input int total, input logic [2:0] sz, input logic [7:0] bl,
                               input logic wm, input logic [3:0] wl, input logic [31:0] init,
                               input bit random_ready, output int first_valid);
        build_expected(total, sz, bl, wm, wl, init);
        start_run(total, sz, bl, wm, wl, init);
        collect_beats(random_ready, first_valid);
        // back to idle through done, with no beat beyond the total.
        for (int c = 0; c < 3; c++)
        begin
            @(negedge clk);
            assert (!wvalid) else begin
                $display("CHECK FAILED wvalid: got %h expected %h after last beat",
                         wvalid, 1'b0);
                err_cnt++;
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, err_cnt - errs_before);
    endtask

    // --------------------------------------------------
    // directed tests.
    // --------------------------------------------------
    task automatic test_full_width();
        int errs;
        int fv;
        errs = err_cnt;
        run_checked(12, 3'd5, 8'd3, 1'b0, 4'd0, 32'h1000_0000, 1'b0, fv);
        assert (fv == 3) else begin
            $display("CHECK FAILED first wvalid cycle: got %h expected %h", fv, 3);
            err_cnt++;
        end
        report_test("full_width", errs);
    endtask

    task automatic test_lane_walk();
        int errs;
        int fv;
        errs = err_cnt;
        run_checked(20, 3'd2, 8'd9, 1'b0, 4'd0, 32'h0000_0100, 1'b0, fv);
        report_test("lane_walk", errs);
    endtask

    task automatic test_back_pressure();
        int errs;
        int fv;
        errs = err_cnt;
        run_checked(24, 3'd3, 8'd3, 1'b0, 4'd0, 32'ha5a5_0000, 1'b1, fv);
        report_test("back_pressure", errs);
    endtask

    task automatic test_wrap();
        int errs;
        int fv;
        errs = err_cnt;
        run_checked(8, 3'd4, 8'd7, 1'b1, 4'd0, 32'h5a5a_13f8, 1'b0, fv);
        // final beat sits on word lanes 4 to 7.
        assert ((last_seen_data[4*32 +: 32] & 32'hffff_fc00) == 32'h5a5a_1000) else begin
            $display("CHECK FAILED wdata upper bits: got %h expected %h",
                     last_seen_data[4*32 +: 32] & 32'hffff_fc00, 32'h5a5a_1000);
            err_cnt++;
        end
        report_test("wrap", errs);
    endtask

    task automatic test_zero_beats();
        int errs;
        int fv;
        errs = err_cnt;
        start_run(0, 3'd5, 8'd0, 1'b0, 4'd0, 32'h0000_0000);
        for (int c = 0; c < 20; c++)
        begin
            @(negedge clk);
            assert (!wvalid) else begin
                $display("CHECK FAILED wvalid: got %h expected %h", wvalid, 1'b0);
                err_cnt++;
            end
        end
        run_checked(6, 3'd3, 8'd1, 1'b0, 4'd0, 32'h0000_0042, 1'b0, fv);
        report_test("zero_beats", errs);
    endtask

    initial
    begin
        void'($urandom(32'h770f));
        err_cnt     = 0;
        test_cnt    = 0;
        rst_n       = 1'b0;
        start       = 1'b0;
        total_beats = '0;
        size        = 3'd5;
        burst_len   = 8'd0;
        wrap_mode   = 1'b0;
        wrap_len    = 4'd0;
        init_data   = 32'h0;
        wready      = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (wvalid === 1'b0) else begin
            $display("CHECK FAILED wvalid: got %h expected %h after reset", wvalid, 1'b0);
            err_cnt++;
        end
        assert (wlast === 1'b0) else begin
            $display("CHECK FAILED wlast: got %h expected %h after reset", wlast, 1'b0);
            err_cnt++;
        end
        assert (wdata === '0) else begin
            $display("CHECK FAILED wdata: got %h expected %h after reset",
                     wdata, {data_w{1'b0}});
            err_cnt++;
        end
        assert (wstrb === '0) else begin
            $display("CHECK FAILED wstrb: got %h expected %h after reset",
                     wstrb, {strb_w{1'b0}});
            err_cnt++;
        end
        wready = 1'b1;
        test_full_width();
        test_lane_walk();
        test_back_pressure();
        test_wrap();
        test_zero_beats();
        $display("tests run %0d, errors %0d", test_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
wdata_pkg.sv
wdata_ctrl.sv
wdata_pattern.sv
wdata_lane_mux.sv
wdata_out_stage.sv
wdata_gen.sv
wdata_props.sv
tb_wdata_gen.sv

// File: Makefile
TOP = tb_wdata_gen

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
